//--- hdl/scalar_pkg.sv
// Shared widths, opcodes, instruction layout and run status for the scalar unit and its testbench
package scalar_pkg;

	localparam int DATA_WIDTH    = 32;
	localparam int INSTR_WIDTH   = 32;
	localparam int REG_IDX_WIDTH = 4;
	localparam int NUM_REGS      = 2 ** REG_IDX_WIDTH;
	localparam int IMM_WIDTH     = 16;

	typedef logic [DATA_WIDTH-1:0]    data_t;
	typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;
	typedef logic [IMM_WIDTH-1:0]     imm_t;

	typedef enum logic [3:0] {
		op_nop  = 4'h0,
		op_add  = 4'h1,
		op_sub  = 4'h2,
		op_and  = 4'h3,
		op_or   = 4'h4,
		op_xor  = 4'h5,
		op_addi = 4'h6,
		op_cmp  = 4'h7,
		op_brc  = 4'h8,
		op_jmp  = 4'h9,
		op_sout = 4'ha,
		op_halt = 4'hb
	} opcode_t;

	// Register-register form
	typedef struct packed {
		reg_idx_t    src1;
		reg_idx_t    src2;
		logic [15:0] spare;
	} reg_form_t;

	// Register-immediate form, imm doubles as branch target
	typedef struct packed {
		reg_idx_t   src1;
		logic [3:0] spare;
		imm_t       imm;
	} imm_form_t;

	// Same 24 payload bits, decoded by opcode
	typedef union packed {
		reg_form_t reg_form;
		imm_form_t imm_form;
	} payload_t;

	typedef struct packed {
		opcode_t  opcode;
		reg_idx_t dst;
		payload_t payload;
	} instr_t;

	typedef enum logic [1:0] {
		st_idle = 2'd0,
		st_run  = 2'd1,
		st_halt = 2'd2
	} status_t;

endpackage

//--- hdl/exec_if.sv
// Issue bundle from control to the execute stage, with redirect and write-back notices back
`timescale 1ns/1ns

interface exec_if;

	// Issue side
	logic                 issue_valid;
	scalar_pkg::opcode_t  issue_op;
	scalar_pkg::reg_idx_t issue_dst;
	scalar_pkg::data_t    issue_src_a_data;
	scalar_pkg::data_t    issue_src_b_data;
	scalar_pkg::imm_t     issue_imm;

	// Execute side notices
	logic                 redirect;
	scalar_pkg::imm_t     redirect_target;
	logic                 wb_done;
	scalar_pkg::reg_idx_t wb_dst;
	logic                 halt_seen;

	modport ctrl (
		output issue_valid, issue_op, issue_dst, issue_src_a_data, issue_src_b_data, issue_imm,
		input  redirect, redirect_target, wb_done, wb_dst, halt_seen
	);

	modport alu (
		input  issue_valid, issue_op, issue_dst, issue_src_a_data, issue_src_b_data, issue_imm,
		output redirect, redirect_target, wb_done, wb_dst, halt_seen
	);

endinterface

//--- hdl/instr_mem.sv
// Program memory: sequential host store port with ack, registered read for instruction fetch
`timescale 1ns/1ns

module instr_mem #(
	parameter int IMEM_ADDR_WIDTH = 6
) (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       store_req,
	input  scalar_pkg::instr_t         store_instr,
	input  logic                       store_open,
	input  logic                       store_rewind,
	output logic                       store_ack,
	input  logic                       fetch_req,
	input  logic [IMEM_ADDR_WIDTH-1:0] fetch_addr,
	output scalar_pkg::instr_t         fetch_instr
);

	localparam int DEPTH = 2 ** IMEM_ADDR_WIDTH;

	logic [scalar_pkg::INSTR_WIDTH-1:0] mem [DEPTH];
	logic [IMEM_ADDR_WIDTH-1:0]         store_ptr;
	logic                               store_accept;

	assign store_accept = store_req & store_open;

	// Store pointer and ack
	always_ff @(posedge clock) begin
		if (reset) begin
			store_ptr <= '0;
			store_ack <= 1'b0;
		end else begin
			store_ack <= store_accept;
			if (store_rewind) begin
				store_ptr <= '0;
			end else if (store_accept) begin
				store_ptr <= store_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (store_accept) begin
			mem[store_ptr] <= store_instr;
		end
		// Output holds while fetch is idle
		if (fetch_req) begin
			fetch_instr <= scalar_pkg::instr_t'(mem[fetch_addr]);
		end
	end

endmodule

//--- hdl/reg_file.sv
// Sixteen scalar registers, two combinational read ports and one write port, cleared on reset
`timescale 1ns/1ns

module reg_file (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 we,
	input  scalar_pkg::reg_idx_t wr_idx,
	input  scalar_pkg::data_t    wr_data,
	input  scalar_pkg::reg_idx_t rd_idx_a,
	input  scalar_pkg::reg_idx_t rd_idx_b,
	output scalar_pkg::data_t    rd_data_a,
	output scalar_pkg::data_t    rd_data_b
);

	scalar_pkg::data_t regs [scalar_pkg::NUM_REGS];

	always_ff @(posedge clock) begin
		if (reset) begin
			regs <= '{default: '0};
		end else if (we) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// No write forwarding, busy bits keep readers off pending writes
	assign rd_data_a = regs[rd_idx_a];
	assign rd_data_b = regs[rd_idx_b];

endmodule

//--- hdl/scalar_alu.sv
// Execute stage: ALU, condition flag, branch resolution, write-back and scalar output strobe
`timescale 1ns/1ns

module scalar_alu (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 enable,
	exec_if.alu                  ex,
	output logic                 we,
	output scalar_pkg::reg_idx_t wr_idx,
	output scalar_pkg::data_t    wr_data,
	output logic                 scalar_valid,
	output scalar_pkg::data_t    scalar_data,
	output logic                 term
);

	logic                 ex_valid;
	scalar_pkg::opcode_t  ex_op;
	scalar_pkg::reg_idx_t ex_dst;
	scalar_pkg::data_t    ex_a;
	scalar_pkg::data_t    ex_b;
	scalar_pkg::imm_t     ex_imm;
	logic                 cond_flag;
	logic                 fire;
	logic                 writes;
	scalar_pkg::data_t    imm_ext;
	scalar_pkg::data_t    result;

	//////////////////////////////////////////////////
	// Execute register
	always_ff @(posedge clock) begin
		if (reset) begin
			ex_valid <= 1'b0;
		end else if (enable) begin
			ex_valid <= ex.issue_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (enable && ex.issue_valid) begin
			ex_op  <= ex.issue_op;
			ex_dst <= ex.issue_dst;
			ex_a   <= ex.issue_src_a_data;
			ex_b   <= ex.issue_src_b_data;
			ex_imm <= ex.issue_imm;
		end
	end

	// Frozen instruction completes once enable returns
	assign fire = ex_valid & enable;

	assign imm_ext = {{(scalar_pkg::DATA_WIDTH - scalar_pkg::IMM_WIDTH){ex_imm[15]}}, ex_imm};

	//////////////////////////////////////////////////
	// Arithmetic and logic
	always_comb begin
		result = '0;
		writes = 1'b1;
		case (ex_op)
			scalar_pkg::op_add:  result = ex_a + ex_b;
			scalar_pkg::op_sub:  result = ex_a - ex_b;
			scalar_pkg::op_and:  result = ex_a & ex_b;
			scalar_pkg::op_or:   result = ex_a | ex_b;
			scalar_pkg::op_xor:  result = ex_a ^ ex_b;
			scalar_pkg::op_addi: result = ex_a + imm_ext;
			default:             writes = 1'b0;
		endcase
	end

	assign we      = fire & writes;
	assign wr_idx  = ex_dst;
	assign wr_data = result;

	// Signed less-than, read by the next brc
	always_ff @(posedge clock) begin
		if (reset) begin
			cond_flag <= 1'b0;
		end else if (fire && ex_op == scalar_pkg::op_cmp) begin
			cond_flag <= $signed(ex_a) < $signed(ex_b);
		end
	end

	//////////////////////////////////////////////////
	// Control notices and outputs
	assign ex.redirect = fire &
		(((ex_op == scalar_pkg::op_brc) & cond_flag) | (ex_op == scalar_pkg::op_jmp));
	assign ex.redirect_target = ex_imm;
	assign ex.wb_done         = fire;
	assign ex.wb_dst          = ex_dst;

	assign scalar_valid = fire & (ex_op == scalar_pkg::op_sout);
	assign scalar_data  = ex_a;
	assign term         = fire & (ex_op == scalar_pkg::op_halt);
	assign ex.halt_seen = term;

endmodule

//--- hdl/issue_ctrl.sv
// Run state, program counter, fetch sequencing and in-order issue gated by register busy bits
`timescale 1ns/1ns

module issue_ctrl #(
	parameter int IMEM_ADDR_WIDTH = 6
) (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       enable,
	input  logic                       start,
	output scalar_pkg::status_t        status,
	output logic                       fetch_req,
	output logic [IMEM_ADDR_WIDTH-1:0] fetch_addr,
	input  scalar_pkg::instr_t         fetch_instr,
	output scalar_pkg::reg_idx_t       rd_idx_a,
	output scalar_pkg::reg_idx_t       rd_idx_b,
	input  scalar_pkg::data_t          rd_data_a,
	input  scalar_pkg::data_t          rd_data_b,
	exec_if.ctrl                       ex
);

	logic [IMEM_ADDR_WIDTH-1:0]      pc;
	logic                            instr_valid;
	logic                            halt_issued;
	logic [scalar_pkg::NUM_REGS-1:0] busy;
	logic [scalar_pkg::NUM_REGS-1:0] busy_next;
	logic                            running;
	logic                            uses_a;
	logic                            uses_b;
	logic                            writes_dst;
	logic                            is_halt;
	logic                            stall;
	logic                            issue_fire;

	assign running = (status == scalar_pkg::st_run);
	assign is_halt = (fetch_instr.opcode == scalar_pkg::op_halt);

	//////////////////////////////////////////////////
	// Operand decode of the payload union
	always_comb begin
		uses_a     = 1'b0;
		uses_b     = 1'b0;
		writes_dst = 1'b0;
		// src1 occupies the same bits in both forms
		rd_idx_a   = fetch_instr.payload.reg_form.src1;
		rd_idx_b   = '0;
		case (fetch_instr.opcode)
			scalar_pkg::op_add, scalar_pkg::op_sub, scalar_pkg::op_and,
			scalar_pkg::op_or, scalar_pkg::op_xor: begin
				uses_a     = 1'b1;
				uses_b     = 1'b1;
				writes_dst = 1'b1;
				rd_idx_b   = fetch_instr.payload.reg_form.src2;
			end
			scalar_pkg::op_cmp: begin
				uses_a   = 1'b1;
				uses_b   = 1'b1;
				rd_idx_b = fetch_instr.payload.reg_form.src2;
			end
			scalar_pkg::op_addi: begin
				uses_a     = 1'b1;
				writes_dst = 1'b1;
			end
			scalar_pkg::op_sout: begin
				uses_a = 1'b1;
			end
			default: begin
				uses_a = 1'b0;
			end
		endcase
	end

	// Wait on any pending write to a source or to the destination
	assign stall = (uses_a & busy[rd_idx_a]) |
		(uses_b & busy[rd_idx_b]) |
		(writes_dst & busy[fetch_instr.dst]);

	// Instruction behind a taken branch is dropped without issue
	assign issue_fire = enable & running & instr_valid & ~halt_issued & ~ex.redirect & ~stall;

	// Refill on redirect, on an empty slot, or behind an issue
	assign fetch_req = enable & running & ~halt_issued &
		(ex.redirect | ~instr_valid | (issue_fire & ~is_halt));
	assign fetch_addr = ex.redirect ? ex.redirect_target[IMEM_ADDR_WIDTH-1:0] : pc;

	// Issue strobe and operands
	assign ex.issue_valid      = issue_fire;
	assign ex.issue_op         = fetch_instr.opcode;
	assign ex.issue_dst        = fetch_instr.dst;
	assign ex.issue_src_a_data = rd_data_a;
	assign ex.issue_src_b_data = rd_data_b;
	assign ex.issue_imm        = fetch_instr.payload.imm_form.imm;

	// Set at issue wins over a clear in the same cycle
	always_comb begin
		busy_next = busy;
		if (ex.wb_done) begin
			busy_next[ex.wb_dst] = 1'b0;
		end
		if (issue_fire && writes_dst) begin
			busy_next[fetch_instr.dst] = 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Run state and pipeline control
	always_ff @(posedge clock) begin
		if (reset) begin
			status      <= scalar_pkg::st_idle;
			pc          <= '0;
			instr_valid <= 1'b0;
			halt_issued <= 1'b0;
			busy        <= '0;
		end else if (start && !running) begin
			status      <= scalar_pkg::st_run;
			pc          <= '0;
			instr_valid <= 1'b0;
			halt_issued <= 1'b0;
			busy        <= '0;
		end else if (enable) begin
			if (ex.halt_seen) begin
				status <= scalar_pkg::st_halt;
			end
			if (fetch_req) begin
				pc          <= fetch_addr + 1'b1;
				instr_valid <= 1'b1;
			end else if (issue_fire || ex.redirect) begin
				instr_valid <= 1'b0;
			end
			if (issue_fire && is_halt) begin
				halt_issued <= 1'b1;
			end
			busy <= busy_next;
		end
	end

endmodule

//--- hdl/scalar_unit.sv
// Scalar unit top level: ties control, instruction memory, registers and execute stage together
`timescale 1ns/1ns

module scalar_unit #(
	parameter int IMEM_ADDR_WIDTH = 6
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                enable,
	input  logic                store_req,
	input  scalar_pkg::instr_t  store_instr,
	input  logic                start,
	output logic                store_ack,
	output logic                scalar_valid,
	output scalar_pkg::data_t   scalar_data,
	output logic                term,
	output scalar_pkg::status_t status
);

	logic                       fetch_req;
	logic [IMEM_ADDR_WIDTH-1:0] fetch_addr;
	scalar_pkg::instr_t         fetch_instr;
	scalar_pkg::reg_idx_t       rd_idx_a;
	scalar_pkg::reg_idx_t       rd_idx_b;
	scalar_pkg::data_t          rd_data_a;
	scalar_pkg::data_t          rd_data_b;
	logic                       we;
	scalar_pkg::reg_idx_t       wr_idx;
	scalar_pkg::data_t          wr_data;

	exec_if ex_bus ();

	//////////////////////////////////////////////////
	// Front end
	issue_ctrl #(
		.IMEM_ADDR_WIDTH(IMEM_ADDR_WIDTH)
	) u_issue_ctrl (
		.clock      (clock),
		.reset      (reset),
		.enable     (enable),
		.start      (start),
		.status     (status),
		.fetch_req  (fetch_req),
		.fetch_addr (fetch_addr),
		.fetch_instr(fetch_instr),
		.rd_idx_a   (rd_idx_a),
		.rd_idx_b   (rd_idx_b),
		.rd_data_a  (rd_data_a),
		.rd_data_b  (rd_data_b),
		.ex         (ex_bus.ctrl)
	);

	// Host may only load while the program is not running
	instr_mem #(
		.IMEM_ADDR_WIDTH(IMEM_ADDR_WIDTH)
	) u_instr_mem (
		.clock       (clock),
		.reset       (reset),
		.store_req   (store_req),
		.store_instr (store_instr),
		.store_open  (status != scalar_pkg::st_run),
		.store_rewind(start),
		.store_ack   (store_ack),
		.fetch_req   (fetch_req),
		.fetch_addr  (fetch_addr),
		.fetch_instr (fetch_instr)
	);

	//////////////////////////////////////////////////
	// Back end
	reg_file u_reg_file (
		.clock    (clock),
		.reset    (reset),
		.we       (we),
		.wr_idx   (wr_idx),
		.wr_data  (wr_data),
		.rd_idx_a (rd_idx_a),
		.rd_idx_b (rd_idx_b),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b)
	);

	scalar_alu u_scalar_alu (
		.clock       (clock),
		.reset       (reset),
		.enable      (enable),
		.ex          (ex_bus.alu),
		.we          (we),
		.wr_idx      (wr_idx),
		.wr_data     (wr_data),
		.scalar_valid(scalar_valid),
		.scalar_data (scalar_data),
		.term        (term)
	);

endmodule

//--- testbench/scalar_unit_chk.sv
// Protocol checker on the scalar unit's top-level ports, attached to every instance by bind
`timescale 1ns/1ns

module scalar_unit_chk (
	input logic                clock,
	input logic                reset,
	input logic                store_req,
	input logic                store_ack,
	input logic                scalar_valid,
	input logic                term,
	input scalar_pkg::status_t status
);

	// Termination is a single-cycle pulse
	term_pulse_once: assert property (@(posedge clock) disable iff (reset)
		term |=> !term) else $error("term held for more than one cycle");

	// No scalar output while the unit sits idle
	idle_no_output: assert property (@(posedge clock) disable iff (reset)
		(status == scalar_pkg::st_idle) |-> !scalar_valid)
		else $error("scalar_valid raised while idle");

	ack_after_req: assert property (@(posedge clock) disable iff (reset)
		store_ack |-> $past(store_req)) else $error("store_ack without a store_req before it");

	// Any store outside a run gets its ack
	req_gets_ack: assert property (@(posedge clock) disable iff (reset)
		(store_req && status != scalar_pkg::st_run) |=> store_ack)
		else $error("accepted store_req not acknowledged");

endmodule

bind scalar_unit scalar_unit_chk u_chk (
	.clock       (clock),
	.reset       (reset),
	.store_req   (store_req),
	.store_ack   (store_ack),
	.scalar_valid(scalar_valid),
	.term        (term),
	.status      (status)
);

//--- testbench/tb_scalar_unit.sv
// Self-checking testbench for the scalar unit: random programs run against an interpreter model
`timescale 1ns/1ns

module tb_scalar_unit;

	localparam int NUM_PROGS   = 40;
	localparam int MAX_LEN     = 24;
	localparam int CLK_PERIOD  = 8;
	// Four cycles per instruction of the longest program, plus a margin per program
	localparam int TIMEOUT_CYC = NUM_PROGS * MAX_LEN * 4 + NUM_PROGS * 32 + 200;

	logic                clock;
	logic                reset;
	logic                enable;
	logic                store_req;
	scalar_pkg::instr_t  store_instr;
	logic                start;
	logic                store_ack;
	logic                scalar_valid;
	scalar_pkg::data_t   scalar_data;
	logic                term;
	scalar_pkg::status_t status;

	scalar_pkg::instr_t  prog [$];
	scalar_pkg::data_t   expect_q [$];
	scalar_pkg::data_t   model_regs [scalar_pkg::NUM_REGS];
	logic                model_flag;
	logic                term_seen;

	// Weighted opcode pick, entries from 10 on only in branch programs
	scalar_pkg::opcode_t op_table [14] = '{
		scalar_pkg::op_add, scalar_pkg::op_sub, scalar_pkg::op_and, scalar_pkg::op_or,
		scalar_pkg::op_xor, scalar_pkg::op_addi, scalar_pkg::op_addi, scalar_pkg::op_sout,
		scalar_pkg::op_sout, scalar_pkg::op_nop, scalar_pkg::op_cmp, scalar_pkg::op_cmp,
		scalar_pkg::op_brc, scalar_pkg::op_jmp
	};

	scalar_unit #(
		.IMEM_ADDR_WIDTH(6)
	) dut0 (
		.clock       (clock),
		.reset       (reset),
		.enable      (enable),
		.store_req   (store_req),
		.store_instr (store_instr),
		.start       (start),
		.store_ack   (store_ack),
		.scalar_valid(scalar_valid),
		.scalar_data (scalar_data),
		.term        (term),
		.status      (status)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "Value mismatch on %s", name);
		end
	endtask

	task automatic fail_run(input string what);
		$display("ERROR at %0t ns: %s", $time, what);
		$display("SOME TESTS FAILED");
		$fatal(1, "%s", what);
	endtask

	//////////////////////////////////////////////////
	// Program generator and interpreter model
	task automatic build_program(input bit with_branches);
		int                   len;
		int                   k;
		int                   target;
		scalar_pkg::reg_idx_t last_dst;
		scalar_pkg::instr_t   ins;
		len = 8 + $urandom_range(16);
		last_dst = '0;
		prog.delete();
		for (k = 0; k < len - 1; k++) begin
			ins = scalar_pkg::instr_t'($urandom);
			ins.opcode = op_table[$urandom_range(with_branches ? 13 : 9)];
			// src1 sits in the same bits in both forms
			if ($urandom_range(1) == 1) begin
				ins.payload.reg_form.src1 = last_dst;
			end
			if (ins.opcode inside {scalar_pkg::op_brc, scalar_pkg::op_jmp}) begin
				target = $urandom_range(len - 1, k + 1);
				ins.payload.imm_form.imm = scalar_pkg::imm_t'(target);
			end
			if (ins.opcode inside {scalar_pkg::op_add, scalar_pkg::op_sub, scalar_pkg::op_and,
				scalar_pkg::op_or, scalar_pkg::op_xor, scalar_pkg::op_addi}) begin
				last_dst = ins.dst;
			end
			prog.push_back(ins);
		end
		ins = '0;
		ins.opcode = scalar_pkg::op_halt;
		prog.push_back(ins);
	endtask

	function automatic void run_model();
		int                 pc;
		bit                 done;
		scalar_pkg::instr_t ins;
		scalar_pkg::data_t  ra;
		scalar_pkg::data_t  rb;
		scalar_pkg::data_t  ri;
		scalar_pkg::data_t  ext;
		pc = 0;
		done = 1'b0;
		expect_q.delete();
		while (!done) begin
			ins = prog[pc];
			pc++;
			ra  = model_regs[ins.payload.reg_form.src1];
			rb  = model_regs[ins.payload.reg_form.src2];
			ri  = model_regs[ins.payload.imm_form.src1];
			ext = {{16{ins.payload.imm_form.imm[15]}}, ins.payload.imm_form.imm};
			case (ins.opcode)
				scalar_pkg::op_add:  model_regs[ins.dst] = ra + rb;
				scalar_pkg::op_sub:  model_regs[ins.dst] = ra - rb;
				scalar_pkg::op_and:  model_regs[ins.dst] = ra & rb;
				scalar_pkg::op_or:   model_regs[ins.dst] = ra | rb;
				scalar_pkg::op_xor:  model_regs[ins.dst] = ra ^ rb;
				scalar_pkg::op_addi: model_regs[ins.dst] = ri + ext;
				scalar_pkg::op_cmp:  model_flag = ($signed(ra) < $signed(rb));
				scalar_pkg::op_brc:  pc = model_flag ? int'(ins.payload.imm_form.imm) : pc;
				scalar_pkg::op_jmp:  pc = int'(ins.payload.imm_form.imm);
				scalar_pkg::op_sout: expect_q.push_back(ri);
				scalar_pkg::op_halt: done = 1'b1;
				default:             done = done;
			endcase
		end
	endfunction

	//////////////////////////////////////////////////
	// Host side stimulus
	task automatic load_program();
		foreach (prog[i]) begin
			@(negedge clock);
			check_value("store_ack", store_ack, (i > 0));
			store_req   = 1'b1;
			store_instr = prog[i];
		end
		@(negedge clock);
		check_value("store_ack", store_ack, 1);
		store_req = 1'b0;
		@(negedge clock);
		check_value("store_ack", store_ack, 0);
	endtask

	task automatic run_program(input bit jitter);
		int idle_left;
		idle_left = 0;
		@(negedge clock);
		term_seen = 1'b0;
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
		check_value("status", status, scalar_pkg::st_run);
		while (!term_seen) begin
			@(negedge clock);
			if (idle_left > 0) begin
				idle_left--;
			end else if (jitter && $urandom_range(15) == 0) begin
				idle_left = $urandom_range(6, 1);
			end
			enable = (idle_left == 0);
		end
		enable = 1'b1;
		// Quiet period, the monitor flags any late output
		repeat (4) @(negedge clock);
		check_value("status", status, scalar_pkg::st_halt);
	endtask

	// Output monitor, sampled at the edge the DUT acts on
	always @(posedge clock) begin
		if (!reset && scalar_valid) begin
			if (term_seen) begin
				fail_run("scalar_valid appeared after term");
			end else if (expect_q.size() == 0) begin
				fail_run("scalar_valid appeared with no output expected by the model");
			end else begin
				check_value("scalar_data", scalar_data, expect_q.pop_front());
			end
		end
		if (!reset && term) begin
			if (term_seen) begin
				fail_run("more than one term pulse in one run");
			end else if (expect_q.size() != 0) begin
				fail_run("term arrived before all expected scalar outputs");
			end
			term_seen = 1'b1;
		end
	end

	initial begin
		#(TIMEOUT_CYC * CLK_PERIOD);
		$display("ERROR: watchdog expired, the run did not finish in time");
		$display("SOME TESTS FAILED");
		$fatal(1, "Timeout");
	end

	initial begin
		int p;
		void'($urandom(32'he362));
		clock       = 1'b0;
		reset       = 1'b1;
		enable      = 1'b1;
		store_req   = 1'b0;
		store_instr = '0;
		start       = 1'b0;
		model_flag  = 1'b0;
		term_seen   = 1'b0;
		foreach (model_regs[i]) begin
			model_regs[i] = '0;
		end
		repeat (3) @(negedge clock);
		reset = 1'b0;
		@(negedge clock);
		check_value("status", status, scalar_pkg::st_idle);
		check_value("term", term, 0);
		check_value("scalar_valid", scalar_valid, 0);
		// Plain arithmetic first, then branches, then enable gaps on top
		for (p = 0; p < NUM_PROGS; p++) begin
			build_program(p >= NUM_PROGS / 4);
			run_model();
			load_program();
			run_program(p >= NUM_PROGS / 2);
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

//--- compile.f
hdl/scalar_pkg.sv
hdl/exec_if.sv
hdl/instr_mem.sv
hdl/reg_file.sv
hdl/scalar_alu.sv
hdl/issue_ctrl.sv
hdl/scalar_unit.sv
testbench/scalar_unit_chk.sv
testbench/tb_scalar_unit.sv

//--- Makefile
# Verilator build and run for the scalar unit testbench

VERILATOR ?= verilator
TOP       ?= tb_scalar_unit
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
